// File: logic/neo_pcm_pkg.sv
`default_nettype none

package neo_pcm_pkg;

	// Widths
	localparam int SIZE_W        = 32;
	localparam int ADDR_W        = 26;  // Memory byte address
	localparam int SAMPLE_ADDR_W = 24;
	localparam int HDR_ADDR_W    = 27;
	localparam int HDR_OFS_W     = 12;  // Offset inside the 4 KiB header

	// Cartridge header layout
	localparam logic [HDR_OFS_W-1:0] HDR_SIZES_FIRST = 12'd4;
	localparam logic [HDR_OFS_W-1:0] HDR_SIZES_LAST  = 12'd27;
	localparam logic [HDR_OFS_W-1:0] HDR_END         = 12'hFFF;

	// Sample channels, A and B
	localparam int NUM_CH    = 2;
	localparam int CH_IDX_W  = (NUM_CH > 1) ? $clog2(NUM_CH) : 1;

	// Midpoint of an unsigned sample byte
	localparam logic [7:0] PCM_SILENCE = 8'h80;

	// Byte window of one ADPCM region
	typedef struct packed {
		logic [ADDR_W-1:0]        base;
		logic [SAMPLE_ADDR_W-1:0] mask;
	} sample_window_t;

	typedef struct packed {
		sample_window_t [NUM_CH-1:0] win;
		logic                        enable;
	} pcm_layout_t;

	// Pending word fetch of a channel, req is a toggle
	typedef struct packed {
		logic [ADDR_W-3:0] addr;
		logic              req;
	} word_req_t;

endpackage

`default_nettype wire

// File: logic/rom_header_parser.sv
`default_nettype none

module rom_header_parser (
	input  wire                                 CLK_48M,
	input  wire                                 pll_locked,
	input  wire                                 dl_active,
	input  wire                                 dl_wr,
	input  wire  [neo_pcm_pkg::HDR_ADDR_W-1:0]  dl_addr,
	input  wire  [7:0]                          dl_data,
	input  wire                                 dl_no_adpcm,
	output neo_pcm_pkg::pcm_layout_t            layout
);

	import neo_pcm_pkg::*;

	// Size fields in header order, little endian
	logic [SIZE_W-1:0] size_p;
	logic [SIZE_W-1:0] size_s;
	logic [SIZE_W-1:0] size_m;
	logic [SIZE_W-1:0] size_v1;
	logic [SIZE_W-1:0] size_v2;
	logic [SIZE_W-1:0] size_c;

	logic                 hdr_wr;
	logic [HDR_OFS_W-1:0] hdr_ofs;
	logic                 size_wr;
	logic                 hdr_last;

	logic [SAMPLE_ADDR_W-1:0] mask_v1;
	logic [SAMPLE_ADDR_W-1:0] mask_v2;
	sample_window_t           win_a;
	sample_window_t           win_b;
	pcm_layout_t              layout_next;

	// 2^n - 1 for the smallest n with 2^n >= size
	function automatic logic [SIZE_W-1:0] ceil_mask(input logic [SIZE_W-1:0] size);
		logic [SIZE_W-1:0] m;
		m = size - 1'b1;
		for (int i = 0; i < 5; i++) begin
			m = m | (m >> (1 << i));
		end
		if (size == '0)
			m = '0;
		return m;
	endfunction

	assign hdr_ofs  = dl_addr[HDR_OFS_W-1:0];
	assign hdr_wr   = dl_active && dl_wr && (dl_addr[HDR_ADDR_W-1:HDR_OFS_W] == '0);
	assign size_wr  = hdr_wr && (hdr_ofs >= HDR_SIZES_FIRST) && (hdr_ofs <= HDR_SIZES_LAST);
	assign hdr_last = hdr_wr && (hdr_ofs == HDR_END);

	// Bytes enter at the top of C and ripple down to P
	always_ff @(posedge CLK_48M) begin
		if (size_wr) begin
			{size_c, size_v2, size_v1, size_m, size_s, size_p} <=
				{dl_data, size_c, size_v2, size_v1, size_m, size_s, size_p[SIZE_W-1:8]};
		end
	end

	assign mask_v1 = SAMPLE_ADDR_W'(ceil_mask(size_v1));
	assign mask_v2 = SAMPLE_ADDR_W'(ceil_mask(size_v2));

	// V1 sits right behind the sprite data
	always_comb begin
		win_a.base = ADDR_W'(size_c);
		win_a.mask = mask_v1;
		win_b.base = ADDR_W'(size_c + size_v1);
		win_b.mask = mask_v2;
		if (size_v2 == '0)
			win_b = win_a;  // Merged ADPCM-A and ADPCM-B image
	end

	always_comb begin
		layout_next.win[0] = win_a;
		layout_next.win[1] = win_b;
		layout_next.enable = !dl_no_adpcm;
	end

	always_ff @(posedge CLK_48M or negedge pll_locked) begin
		if (!pll_locked) begin
			layout <= '0;
		end else if (hdr_last) begin
			layout <= layout_next;
		end
	end

endmodule

`default_nettype wire

// File: logic/sample_channel.sv
`default_nettype none

module sample_channel (
	input  wire                                    CLK_48M,
	input  wire                                    pll_locked,
	input  wire                                    rd,
	input  wire  [neo_pcm_pkg::SAMPLE_ADDR_W-1:0]  addr,
	input  neo_pcm_pkg::sample_window_t            window,
	input  wire                                    enable,
	output neo_pcm_pkg::word_req_t                 req,
	input  wire                                    ack,
	input  wire  [31:0]                            word,
	output logic [7:0]                             data,
	output logic                                   ready
);

	import neo_pcm_pkg::*;

	logic                     rd_d;
	logic                     rd_rise;
	logic                     req_tgl;
	logic [SAMPLE_ADDR_W-1:0] offset;     // Masked byte offset of the last read
	logic [SAMPLE_ADDR_W-1:0] new_offset;
	logic                     word_miss;
	logic [ADDR_W-1:0]        byte_addr;

	assign rd_rise    = rd && !rd_d;
	assign new_offset = addr & window.mask;
	assign word_miss  = new_offset[SAMPLE_ADDR_W-1:2] != offset[SAMPLE_ADDR_W-1:2];
	assign ready      = req_tgl == ack;

	always_ff @(posedge CLK_48M or negedge pll_locked) begin
		if (!pll_locked) begin
			rd_d    <= 1'b0;
			req_tgl <= 1'b0;
			offset  <= '1;  // First read always fetches
		end else begin
			rd_d <= rd;
			// Edges while a fetch is in flight are dropped
			if (rd_rise && enable && ready) begin
				offset <= new_offset;
				if (word_miss)
					req_tgl <= ~req_tgl;
			end
		end
	end

	assign byte_addr = window.base + ADDR_W'(offset);

	always_comb begin
		req.addr = byte_addr[ADDR_W-1:2];
		req.req  = req_tgl;
	end

	always_comb begin
		if (!enable) begin
			data = PCM_SILENCE;
		end else begin
			case (offset[1:0])
				2'd0:    data = word[7:0];
				2'd1:    data = word[15:8];
				2'd2:    data = word[23:16];
				default: data = word[31:24];
			endcase
		end
	end

endmodule

`default_nettype wire

// File: logic/sample_arbiter.sv
`default_nettype none

module sample_arbiter (
	input  wire                                             CLK_48M,
	input  wire                                             pll_locked,
	input  neo_pcm_pkg::word_req_t [neo_pcm_pkg::NUM_CH-1:0] ch_req,
	output logic [neo_pcm_pkg::NUM_CH-1:0]                  ch_ack,
	output logic [neo_pcm_pkg::NUM_CH-1:0][31:0]            ch_word,
	output logic                                            mem_req,
	output logic [neo_pcm_pkg::ADDR_W-3:0]                  mem_addr,
	input  wire                                             mem_ack,
	input  wire  [31:0]                                     mem_q
);

	import neo_pcm_pkg::*;

	logic [NUM_CH-1:0]   pending;
	logic                any_pending;
	logic [CH_IDX_W-1:0] grant;
	logic [CH_IDX_W-1:0] ptr;   // Channel with first priority
	logic [CH_IDX_W-1:0] sel;   // Channel being served
	logic                busy;
	logic                mem_done;

	always_comb begin
		for (int i = 0; i < NUM_CH; i++) begin
			pending[i] = ch_req[i].req != ch_ack[i];
		end
	end

	// Round robin starting at ptr
	always_comb begin
		int unsigned idx;
		grant       = ptr;
		any_pending = 1'b0;
		for (int k = NUM_CH - 1; k >= 0; k--) begin
			idx = (int'(ptr) + k) % NUM_CH;
			if (pending[idx]) begin
				grant       = CH_IDX_W'(idx);
				any_pending = 1'b1;
			end
		end
	end

	assign mem_done = busy && (mem_ack == mem_req);

	always_ff @(posedge CLK_48M or negedge pll_locked) begin
		if (!pll_locked) begin
			busy     <= 1'b0;
			ptr      <= '0;
			sel      <= '0;
			mem_req  <= 1'b0;
			mem_addr <= '0;
			ch_ack   <= '0;
		end else begin
			if (!busy) begin
				if (any_pending) begin
					busy     <= 1'b1;
					sel      <= grant;
					mem_addr <= ch_req[grant].addr;
					mem_req  <= ~mem_req;
				end
			end else if (mem_done) begin
				busy        <= 1'b0;
				ch_ack[sel] <= ~ch_ack[sel];  // Completes the channel toggle
				if (sel == CH_IDX_W'(NUM_CH - 1))
					ptr <= '0;
				else
					ptr <= sel + 1'b1;
			end
		end
	end

	// Word stays until the next fetch of that channel
	always_ff @(posedge CLK_48M) begin
		if (mem_done)
			ch_word[sel] <= mem_q;
	end

endmodule

`default_nettype wire

// File: logic/neo_pcm_top.sv
`default_nettype none

module neo_pcm_top (
	input  wire                                    CLK_48M,
	input  wire                                    pll_locked,
	input  wire                                    dl_active,
	input  wire                                    dl_wr,
	input  wire                                    dl_no_adpcm,
	input  wire  [neo_pcm_pkg::HDR_ADDR_W-1:0]     dl_addr,
	input  wire  [7:0]                             dl_data,
	input  wire  [neo_pcm_pkg::NUM_CH-1:0]         sample_rd,
	input  wire  [3:0]                             adpcma_bank,
	input  wire  [19:0]                            adpcma_addr,
	input  wire  [23:0]                            adpcmb_addr,
	output logic [neo_pcm_pkg::NUM_CH-1:0][7:0]    sample_data,
	output logic [neo_pcm_pkg::NUM_CH-1:0]         sample_ready,
	output logic                                   mem_req,
	output logic [neo_pcm_pkg::ADDR_W-3:0]         mem_addr,
	input  wire                                    mem_ack,
	input  wire  [31:0]                            mem_q
);

	import neo_pcm_pkg::*;

	pcm_layout_t                          layout;
	logic [NUM_CH-1:0][SAMPLE_ADDR_W-1:0] ch_addr;
	word_req_t [NUM_CH-1:0]               ch_req;
	logic [NUM_CH-1:0]                    ch_ack;
	logic [NUM_CH-1:0][31:0]              ch_word;

	assign ch_addr[0] = {adpcma_bank, adpcma_addr};  // Bank on top for ADPCM-A
	assign ch_addr[1] = adpcmb_addr;

	rom_header_parser u_parser (
		.CLK_48M     (CLK_48M),
		.pll_locked  (pll_locked),
		.dl_active   (dl_active),
		.dl_wr       (dl_wr),
		.dl_addr     (dl_addr),
		.dl_data     (dl_data),
		.dl_no_adpcm (dl_no_adpcm),
		.layout      (layout)
	);

	for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
		sample_channel u_ch (
			.CLK_48M    (CLK_48M),
			.pll_locked (pll_locked),
			.rd         (sample_rd[i]),
			.addr       (ch_addr[i]),
			.window     (layout.win[i]),
			.enable     (layout.enable),
			.req        (ch_req[i]),
			.ack        (ch_ack[i]),
			.word       (ch_word[i]),
			.data       (sample_data[i]),
			.ready      (sample_ready[i])
		);
	end

	sample_arbiter u_arb (
		.CLK_48M    (CLK_48M),
		.pll_locked (pll_locked),
		.ch_req     (ch_req),
		.ch_ack     (ch_ack),
		.ch_word    (ch_word),
		.mem_req    (mem_req),
		.mem_addr   (mem_addr),
		.mem_ack    (mem_ack),
		.mem_q      (mem_q)
	);

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
	output logic CLK_48M,
	output logic pll_locked
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		CLK_48M    = 1'b0;
		pll_locked = 1'b0;
		repeat (4) @(posedge CLK_48M);
		@(negedge CLK_48M);
		pll_locked = 1'b1;  // Release away from the active edge
	end

	always #2 CLK_48M = ~CLK_48M;

endmodule

`default_nettype wire

// File: verification/pcm_checker.sv
`default_nettype none

module pcm_checker (
	input  wire                                  CLK_48M,
	input  wire                                  pll_locked,
	input  wire  [neo_pcm_pkg::NUM_CH-1:0]       sample_rd,
	input  wire  [3:0]                           adpcma_bank,
	input  wire  [19:0]                          adpcma_addr,
	input  wire  [23:0]                          adpcmb_addr,
	input  wire  [neo_pcm_pkg::NUM_CH-1:0][7:0]  sample_data,
	input  wire  [neo_pcm_pkg::NUM_CH-1:0]       sample_ready,
	input  wire                                  mem_req,
	input  wire  [31:0]                          cfg_c,
	input  wire  [31:0]                          cfg_v1,
	input  wire  [31:0]                          cfg_v2,
	input  wire                                  cfg_no_adpcm,
	output int                                   reads_checked,
	output int                                   errors,
	output int                                   timeouts
);

	timeunit 1ns;
	timeprecision 100ps;

	import neo_pcm_pkg::*;

	localparam int READY_LIMIT = 300;

	logic [SAMPLE_ADDR_W-1:0] last_ofs [NUM_CH];  // Model of the latched offsets
	logic [31:0]              held [NUM_CH];
	logic                     mem_req_q;
	int                       fetches_expected;   // Word misses seen so far
	int                       fetches_seen;       // mem_req toggles so far

	function automatic logic [SAMPLE_ADDR_W-1:0] region_mask(input logic [31:0] size);
		logic [32:0] span;
		span = 33'd1;
		while (span < {1'b0, size})
			span = span << 1;
		return SAMPLE_ADDR_W'(span - 1'b1);
	endfunction

	task automatic check_read(input int c, input logic [SAMPLE_ADDR_W-1:0] a);
		logic [ADDR_W-1:0]        base;
		logic [ADDR_W-1:0]        byte_addr;
		logic [SAMPLE_ADDR_W-1:0] mask;
		logic [SAMPLE_ADDR_W-1:0] ofs;
		logic                     miss;
		logic [7:0]               exp;
		int                       t;
		if (c == 0 || cfg_v2 == '0) begin  // Merged image uses window A
			base = ADDR_W'(cfg_c);
			mask = region_mask(cfg_v1);
		end else begin
			base = ADDR_W'(cfg_c + cfg_v1);
			mask = region_mask(cfg_v2);
		end
		ofs  = a & mask;
		miss = 1'b0;
		exp  = 8'h80;
		if (!cfg_no_adpcm) begin
			miss        = ofs[SAMPLE_ADDR_W-1:2] != last_ofs[c][SAMPLE_ADDR_W-1:2];
			last_ofs[c] = ofs;
			if (miss) begin
				byte_addr = base + ADDR_W'(ofs);
				held[c]   = {8'h00, byte_addr[ADDR_W-1:2]} ^ 32'hA5A5_0000;
				fetches_expected++;
			end
			exp = held[c][8*ofs[1:0] +: 8];
		end
		@(negedge CLK_48M);
		if (sample_ready[c] !== !miss) begin
			errors++;
			$display("Fail sample_ready[%0d]: got %h, expected %h", c, sample_ready[c], !miss);
		end
		for (t = 0; t < READY_LIMIT && sample_ready[c] !== 1'b1; t++)
			@(negedge CLK_48M);
		if (sample_ready[c] !== 1'b1) begin
			timeouts++;
			$display("Timeout: channel %0d never became ready after a read", c);
		end else if (sample_data[c] !== exp) begin
			errors++;
			$display("Fail sample_data[%0d]: got %h, expected %h (offset %h)",
				c, sample_data[c], exp, ofs);
		end
		reads_checked++;
	endtask

	initial begin
		int t;
		reads_checked    = 0;
		errors           = 0;
		timeouts         = 0;
		fetches_expected = 0;
		fetches_seen     = 0;
		for (int c = 0; c < NUM_CH; c++) begin
			last_ofs[c] = '1;
			held[c]     = '0;
		end
		for (t = 0; t < 100 && !pll_locked; t++)
			@(posedge CLK_48M);
		if (!pll_locked) begin
			timeouts++;
			$display("Timeout: pll_locked never went high");
		end else begin
			repeat (4) begin
				@(negedge CLK_48M);
				if (sample_ready !== '1) begin
					errors++;
					$display("Fail sample_ready: got %h, expected %h",
						sample_ready, {NUM_CH{1'b1}});
				end
				if (mem_req !== 1'b0) begin
					errors++;
					$display("Fail mem_req: got %h, expected 0", mem_req);
				end
				if (sample_data !== {NUM_CH{8'h80}}) begin
					errors++;
					$display("Fail sample_data: got %h, expected 8080", sample_data);
				end
			end
		end
	end

	// Every toggle of mem_req must belong to a word miss
	always @(negedge CLK_48M) begin
		if (pll_locked && mem_req !== mem_req_q) begin
			fetches_seen++;
			if (fetches_seen > fetches_expected) begin
				errors++;
				$display("Fail mem_req: got %h, expected %h (%0d toggles, %0d fetches due)",
					mem_req, mem_req_q, fetches_seen, fetches_expected);
			end
		end
		mem_req_q <= mem_req;
	end

	for (genvar c = 0; c < NUM_CH; c++) begin : g_watch
		logic rd_q;
		always @(posedge CLK_48M)
			rd_q <= sample_rd[c];
		always @(posedge CLK_48M) begin
			if (pll_locked && sample_rd[c] && !rd_q)
				check_read(c, (c == 0) ? {adpcma_bank, adpcma_addr} : adpcmb_addr);
		end
	end

endmodule

`default_nettype wire

// File: verification/neo_pcm_asserts.sv
`default_nettype none

module neo_pcm_asserts (
	input wire                    CLK_48M,
	input wire                    pll_locked,
	input wire                    rd,
	input wire                    enable,
	input neo_pcm_pkg::word_req_t req,
	input wire                    ack,
	input wire                    ready
);

	timeunit 1ns;
	timeprecision 100ps;

	// A toggle follows a rising rd seen at the previous edge
	req_after_rd: assert property (@(posedge CLK_48M) disable iff (!pll_locked)
		(req.req != $past(req.req)) |-> ($past(rd) && !$past(rd, 2)))
		else $error("req toggled without a rising edge on rd");

	idle_when_off: assert property (@(posedge CLK_48M) disable iff (!pll_locked)
		!enable |-> ready)
		else $error("ready low while the layout is disabled");

	one_in_flight: assert property (@(posedge CLK_48M) disable iff (!pll_locked)
		(req.req != $past(req.req)) |-> $past(req.req == ack))
		else $error("req toggled again before ack returned");

endmodule

`default_nettype wire

// File: verification/neo_pcm_tb.sv
`default_nettype none

module neo_pcm_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import neo_pcm_pkg::*;

	localparam int NUM_ROWS   = 5;
	localparam int READ_LIMIT = 1000;

	typedef struct packed {
		logic [31:0] c_size;
		logic [31:0] v1_size;
		logic [31:0] v2_size;
		logic        no_adpcm;
		logic [1:0]  ch;     // 0 A, 1 B, 2 both
		logic [3:0]  bank;
		logic [23:0] addr;
		logic [7:0]  reads;
	} stim_row_t;

	logic                    CLK_48M;
	logic                    pll_locked;
	logic                    dl_active;
	logic                    dl_wr;
	logic                    dl_no_adpcm;
	logic [HDR_ADDR_W-1:0]   dl_addr;
	logic [7:0]              dl_data;
	logic [NUM_CH-1:0]       sample_rd;
	logic [3:0]              adpcma_bank;
	logic [19:0]             adpcma_addr;
	logic [23:0]             adpcmb_addr;
	logic [NUM_CH-1:0][7:0]  sample_data;
	logic [NUM_CH-1:0]       sample_ready;
	logic                    mem_req;
	logic [ADDR_W-3:0]       mem_addr;
	logic                    mem_ack;
	logic [31:0]             mem_q;
	logic [31:0]             cfg_c;
	logic [31:0]             cfg_v1;
	logic [31:0]             cfg_v2;
	logic                    cfg_no_adpcm;
	int                      reads_checked;
	int                      reads_issued;
	int                      errors;
	int                      timeouts;
	logic                    stalled;
	logic [31:0]             stim_lfsr;
	logic [31:0]             mem_lfsr;
	stim_row_t               rows [NUM_ROWS];

	bind sample_channel neo_pcm_asserts u_asserts (
		.CLK_48M    (CLK_48M),
		.pll_locked (pll_locked),
		.rd         (rd),
		.enable     (enable),
		.req        (req),
		.ack        (ack),
		.ready      (ready)
	);

	tb_clock_gen u_clk (.CLK_48M(CLK_48M), .pll_locked(pll_locked));

	neo_pcm_top uut (
		.CLK_48M(CLK_48M), .pll_locked(pll_locked),
		.dl_active(dl_active), .dl_wr(dl_wr), .dl_no_adpcm(dl_no_adpcm),
		.dl_addr(dl_addr), .dl_data(dl_data),
		.sample_rd(sample_rd), .adpcma_bank(adpcma_bank),
		.adpcma_addr(adpcma_addr), .adpcmb_addr(adpcmb_addr),
		.sample_data(sample_data), .sample_ready(sample_ready),
		.mem_req(mem_req), .mem_addr(mem_addr), .mem_ack(mem_ack), .mem_q(mem_q)
	);

	pcm_checker u_check (
		.CLK_48M(CLK_48M), .pll_locked(pll_locked), .sample_rd(sample_rd),
		.adpcma_bank(adpcma_bank), .adpcma_addr(adpcma_addr), .adpcmb_addr(adpcmb_addr),
		.sample_data(sample_data), .sample_ready(sample_ready), .mem_req(mem_req),
		.cfg_c(cfg_c), .cfg_v1(cfg_v1), .cfg_v2(cfg_v2), .cfg_no_adpcm(cfg_no_adpcm),
		.reads_checked(reads_checked), .errors(errors), .timeouts(timeouts)
	);

	// Fibonacci LFSR x^32+x^22+x^2+x+1, one step
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	task automatic take_bits(inout logic [31:0] state, input int n, output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			state = lfsr_step(state);
			bits  = {bits[30:0], state[0]};
		end
	endtask

	function automatic logic [7:0] header_byte(input int ofs, input stim_row_t r);
		case (ofs / 4)
			4:       return r.v1_size[8*(ofs%4) +: 8];
			5:       return r.v2_size[8*(ofs%4) +: 8];
			6:       return r.c_size[8*(ofs%4) +: 8];
			default: return 8'h00;  // P, S, M sizes left zero
		endcase
	endfunction

	task automatic stream_header(input stim_row_t r);
		for (int i = 0; i < 4096; i++) begin
			@(negedge CLK_48M);
			dl_active   = 1'b1;
			dl_wr       = 1'b1;
			dl_no_adpcm = r.no_adpcm;
			dl_addr     = HDR_ADDR_W'(i);
			dl_data     = header_byte(i, r);
		end
		@(negedge CLK_48M);
		dl_wr     = 1'b0;
		dl_active = 1'b0;
		@(negedge CLK_48M);
	endtask

	task automatic wait_checked();
		int t;
		t = 0;
		while (reads_checked < reads_issued && t < READ_LIMIT) begin
			@(posedge CLK_48M);
			t++;
		end
		if (reads_checked < reads_issued) begin
			$display("Timeout: only %0d of %0d reads were checked", reads_checked, reads_issued);
			stalled = 1'b1;
		end
	endtask

	task automatic run_reads(input stim_row_t r);
		logic [31:0] step;
		@(negedge CLK_48M);
		adpcma_bank = r.bank;
		adpcma_addr = r.addr[19:0];
		adpcmb_addr = (r.ch == 2'd2) ? (r.addr ^ 24'h01_0F00) : r.addr;
		for (int n = 0; n < int'(r.reads) && !stalled; n++) begin
			if (r.ch != 2'd1) begin
				take_bits(stim_lfsr, 4, step);
				adpcma_addr  = adpcma_addr + step[19:0];
				sample_rd[0] = 1'b1;
				reads_issued++;
			end
			if (r.ch != 2'd0) begin
				take_bits(stim_lfsr, 4, step);
				adpcmb_addr  = adpcmb_addr + step[23:0];
				sample_rd[1] = 1'b1;
				reads_issued++;
			end
			wait_checked();
			@(negedge CLK_48M);
			sample_rd = '0;
			@(negedge CLK_48M);
		end
	endtask

	// Memory model, ack after 1 to 8 cycles
	initial begin
		logic [31:0] bits;
		mem_lfsr = 32'hda16;
		mem_ack  = 1'b0;
		mem_q    = '0;
		forever begin
			@(negedge CLK_48M);
			if (pll_locked && mem_req != mem_ack) begin
				take_bits(mem_lfsr, 3, bits);
				repeat (int'(bits[2:0])) @(negedge CLK_48M);
				mem_q   = {8'h00, mem_addr} ^ 32'hA5A5_0000;
				mem_ack = mem_req;
			end
		end
	end

	initial begin
		stim_lfsr    = 32'hda16;
		reads_issued = 0;
		stalled      = 1'b0;
		dl_active    = 1'b0;
		dl_wr        = 1'b0;
		dl_no_adpcm  = 1'b0;
		dl_addr      = '0;
		dl_data      = '0;
		sample_rd    = '0;
		adpcma_bank  = '0;
		adpcma_addr  = '0;
		adpcmb_addr  = '0;
		cfg_c        = '0;
		cfg_v1       = '0;
		cfg_v2       = '0;
		cfg_no_adpcm = 1'b0;
		rows[0] = '{32'h4_0000, 32'h2_0000, 32'h1_0000, 1'b0, 2'd0, 4'h3, 24'h01_2345, 8'd16};
		rows[1] = '{32'h4_0000, 32'h2_0000, 32'h1_0000, 1'b0, 2'd1, 4'h0, 24'h00_F3F0, 8'd16};
		rows[2] = '{32'h8_0000, 32'h10_0000, 32'h0, 1'b0, 2'd1, 4'h0, 24'h03_7777, 8'd12};
		rows[3] = '{32'h4_0000, 32'h2_0000, 32'h1_0000, 1'b1, 2'd2, 4'h5, 24'h00_1000, 8'd8};
		rows[4] = '{32'h20_0000, 32'h8_0000, 32'h3_0000, 1'b0, 2'd2, 4'h2, 24'h06_0100, 8'd24};

		for (int t = 0; t < 100 && !pll_locked; t++)
			@(posedge CLK_48M);
		if (!pll_locked) begin
			$display("Timeout: reset was never released");
			stalled = 1'b1;
		end
		repeat (8) @(negedge CLK_48M);  // Idle checks after reset

		for (int i = 0; i < NUM_ROWS && !stalled; i++) begin
			cfg_c        = rows[i].c_size;
			cfg_v1       = rows[i].v1_size;
			cfg_v2       = rows[i].v2_size;
			cfg_no_adpcm = rows[i].no_adpcm;
			stream_header(rows[i]);
			run_reads(rows[i]);
		end

		$display("Reads checked %0d, value errors %0d, timeouts %0d, stalled %0d",
			reads_checked, errors, timeouts, stalled);
		if (errors == 0 && timeouts == 0 && !stalled) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
logic/neo_pcm_pkg.sv
logic/rom_header_parser.sv
logic/sample_channel.sv
logic/sample_arbiter.sv
logic/neo_pcm_top.sv
verification/tb_clock_gen.sv
verification/pcm_checker.sv
verification/neo_pcm_asserts.sv
verification/neo_pcm_tb.sv

// File: Bender.yml
package:
  name: neo_pcm

sources:
  - logic/neo_pcm_pkg.sv
  - logic/rom_header_parser.sv
  - logic/sample_channel.sv
  - logic/sample_arbiter.sv
  - logic/neo_pcm_top.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/pcm_checker.sv
      - verification/neo_pcm_asserts.sv
      - verification/neo_pcm_tb.sv
